// ==== common/pool_pkg.sv ====
package pool_pkg;

  // size and counter width
  localparam int LWIDTH = 8;

  // feature map side length, window size or raster position
  typedef logic [LWIDTH-1:0] size_t;

  // stages in the event delay line
  localparam int DELAY_DEPTH = 32;

  typedef logic [$clog2(DELAY_DEPTH)-1:0] tap_t;

  // fixed part of the pooling buffer latency
  // tap = fea_size - pool_size + POOL_PIPE_LATENCY - 1
  localparam int POOL_PIPE_LATENCY = 8;

  // register stages between the tap and the out_* ports, pool_oe after the first
  localparam int OUT_STAGES = 2;

  // frame state encoding
  localparam logic S_WAIT   = 1'b0;
  localparam logic S_ACTIVE = 1'b1;

endpackage

// ==== common/pool_event_if.sv ====
interface pool_event_if;
  import pool_pkg::*;

  logic ev_begin;    // window begin, one cycle
  logic ev_valid;    // window complete, one cycle
  logic ev_end;      // last pixel of frame
  tap_t tap;         // delay tap, fixed per frame
  logic frame_done;  // registered out_end

  // event source side
  modport scan (
    output ev_begin,
    output ev_valid,
    output ev_end,
    output tap,
    input  frame_done
  );

  // delay and output side
  modport align (
    input  ev_begin,
    input  ev_valid,
    input  ev_end,
    input  tap,
    output frame_done
  );

endinterface

// ==== pool_scan/pool_scan.sv ====
module pool_scan (
  input  logic            clk,
  input  logic            xrst,
  input  logic            in_begin,
  input  logic            in_valid,
  input  pool_pkg::size_t fea_size,
  input  pool_pkg::size_t pool_size,
  output logic            buf_feat_en,
  output pool_pkg::size_t w_pool_size,
  pool_event_if.scan      ev
);
  import pool_pkg::*;

  logic  r_state;
  logic  r_buf_feat_en;

  size_t r_fea_size;
  size_t r_pool_size;
  tap_t  r_tap;

  size_t r_x;       // raster column
  size_t r_y;       // raster row
  size_t r_exec_x;  // column inside window
  size_t r_exec_y;  // row inside window

  logic  start;
  logic  accept;
  logic  row_end;
  size_t tap_calc;
  size_t fea_last;
  size_t pool_last;
  size_t pool_pre;

  // in_begin only counts while waiting
  assign start  = (r_state == S_WAIT) && in_begin;
  assign accept = (r_state == S_ACTIVE) && in_valid;

  assign tap_calc = fea_size - pool_size + size_t'(POOL_PIPE_LATENCY - 1);

  assign fea_last  = r_fea_size - 1'b1;
  assign pool_last = r_pool_size - 1'b1;
  assign pool_pre  = r_pool_size - size_t'(2);

  assign row_end = (r_x == fea_last);

  always_ff @(posedge clk)
    if (!xrst)
      r_state <= S_WAIT;
    else
      case (r_state)
        S_WAIT:
          if (in_begin)
            r_state <= S_ACTIVE;
        S_ACTIVE:
          if (ev.frame_done)
            r_state <= S_WAIT;
        default:
          r_state <= S_WAIT;
      endcase

  // sizes and tap held for the whole frame
  always_ff @(posedge clk)
    if (!xrst)
    begin
      r_fea_size  <= '0;
      r_pool_size <= '0;
      r_tap       <= '0;
    end
    else if (start)
    begin
      r_fea_size  <= fea_size;
      r_pool_size <= pool_size;
      r_tap       <= tap_t'(tap_calc);  // at most 31 for supported sizes
    end

  // feature buffer enable, one cycle after any in_begin
  always_ff @(posedge clk)
    if (!xrst)
      r_buf_feat_en <= 1'b0;
    else
      r_buf_feat_en <= in_begin;

  // raster position, cleared while waiting
  always_ff @(posedge clk)
    if (!xrst || r_state == S_WAIT)
    begin
      r_x <= '0;
      r_y <= '0;
    end
    else if (in_valid)
    begin
      if (row_end)
      begin
        r_x <= '0;
        if (r_y == fea_last)
          r_y <= '0;
        else
          r_y <= r_y + 1'b1;
      end
      else
        r_x <= r_x + 1'b1;
    end

  // window position, x wraps per pixel
  always_ff @(posedge clk)
    if (!xrst || r_state == S_WAIT)
      r_exec_x <= '0;
    else if (in_valid)
    begin
      if (r_exec_x == pool_last)
        r_exec_x <= '0;
      else
        r_exec_x <= r_exec_x + 1'b1;
    end

  // y steps at each row end
  always_ff @(posedge clk)
    if (!xrst || r_state == S_WAIT)
      r_exec_y <= '0;
    else if (in_valid && row_end)
    begin
      if (r_exec_y == pool_last)
        r_exec_y <= '0;
      else
        r_exec_y <= r_exec_y + 1'b1;
    end

  // Events fire only on an accepted pixel, so a stalled stream
  // sitting at a matching position does not repeat them.
  assign ev.ev_begin = accept
                       && r_x == pool_pre
                       && r_y == pool_last;
  assign ev.ev_valid = accept
                       && r_exec_x == pool_last
                       && r_exec_y == pool_last;
  assign ev.ev_end   = accept
                       && row_end
                       && r_y == fea_last;

  assign ev.tap = r_tap;

  assign buf_feat_en = r_buf_feat_en;
  assign w_pool_size = r_pool_size;

endmodule

// ==== hdl/pool_align.sv ====
module pool_align (
  input  logic        clk,
  input  logic        xrst,
  pool_event_if.align ev,
  output logic        out_begin,
  output logic        out_valid,
  output logic        out_end,
  output logic        pool_oe
);
  import pool_pkg::*;

  // per stage {begin, valid, end}
  logic [DELAY_DEPTH-1:0][2:0] r_ev_d;

  logic [2:0] ev_in;
  logic [2:0] ev_tap;

  logic r_begin_d0;
  logic r_valid_d0;
  logic r_end_d0;
  logic r_begin_d1;
  logic r_valid_d1;
  logic r_end_d1;

  assign ev_in = {ev.ev_begin, ev.ev_valid, ev.ev_end};

  // stage 0 loads on the accept edge
  always_ff @(posedge clk)
    if (!xrst)
      r_ev_d <= '0;
    else
      r_ev_d <= {r_ev_d[DELAY_DEPTH-2:0], ev_in};

  // tap matches the buffer latency of this frame
  assign ev_tap = r_ev_d[ev.tap];

  // first output stage, feeds pool_oe
  always_ff @(posedge clk)
    if (!xrst)
    begin
      r_begin_d0 <= 1'b0;
      r_valid_d0 <= 1'b0;
      r_end_d0   <= 1'b0;
    end
    else
    begin
      r_begin_d0 <= ev_tap[2];
      r_valid_d0 <= ev_tap[1];
      r_end_d0   <= ev_tap[0];
    end

  // second output stage
  always_ff @(posedge clk)
    if (!xrst)
    begin
      r_begin_d1 <= 1'b0;
      r_valid_d1 <= 1'b0;
      r_end_d1   <= 1'b0;
    end
    else
    begin
      r_begin_d1 <= r_begin_d0;
      r_valid_d1 <= r_valid_d0;
      r_end_d1   <= r_end_d0;
    end

  assign out_begin = r_begin_d1;
  assign out_valid = r_valid_d1;
  assign out_end   = r_end_d1;

  assign pool_oe = r_valid_d0;  // one cycle ahead of out_valid

  // scan side leaves the active state on this
  assign ev.frame_done = r_end_d1;

endmodule

// ==== hdl/pool_ctrl.sv ====
module pool_ctrl (
  input  logic            clk,
  input  logic            xrst,
  input  logic            in_begin,
  input  logic            in_valid,
  input  logic            in_end,     // frame end comes from the counters
  input  pool_pkg::size_t fea_size,
  input  pool_pkg::size_t pool_size,
  output logic            buf_feat_en,
  output logic            out_begin,
  output logic            out_valid,
  output logic            out_end,
  output logic            pool_oe,
  output pool_pkg::size_t w_pool_size
);

  // events and tap from scan to align, frame_done back
  pool_event_if ev ();

  // frame FSM, counters and event detection
  pool_scan u_scan (
    .clk         (clk),
    .xrst        (xrst),
    .in_begin    (in_begin),
    .in_valid    (in_valid),
    .fea_size    (fea_size),
    .pool_size   (pool_size),
    .buf_feat_en (buf_feat_en),
    .w_pool_size (w_pool_size),
    .ev          (ev)
  );

  // event delay to the pooling buffer, output stages
  pool_align u_align (
    .clk       (clk),
    .xrst      (xrst),
    .ev        (ev),
    .out_begin (out_begin),
    .out_valid (out_valid),
    .out_end   (out_end),
    .pool_oe   (pool_oe)
  );

endmodule

// ==== verification/tb_pool_ctrl.sv ====
module tb_pool_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import pool_pkg::*;

  localparam int FRAME_TIMEOUT = 2000;  // cycles after the last pixel

  logic  clk;
  logic  xrst;
  logic  in_begin;
  logic  in_valid;
  logic  in_end;
  size_t fea_size;
  size_t pool_size;
  logic  buf_feat_en;
  logic  out_begin;
  logic  out_valid;
  logic  out_end;
  logic  pool_oe;
  size_t w_pool_size;

  int          errors;
  int          checks;
  int          cyc;   // rising edges so far
  logic [31:0] lfsr;

  int exp_valid_q[$];
  int exp_begin_q[$];
  int exp_end_q[$];
  int exp_bfe_q[$];
  int valid_q[$];
  int oe_q[$];
  int begin_q[$];
  int end_q[$];
  int bfe_q[$];

  pool_ctrl dut (
    .clk         (clk),
    .xrst        (xrst),
    .in_begin    (in_begin),
    .in_valid    (in_valid),
    .in_end      (in_end),
    .fea_size    (fea_size),
    .pool_size   (pool_size),
    .buf_feat_en (buf_feat_en),
    .out_begin   (out_begin),
    .out_valid   (out_valid),
    .out_end     (out_end),
    .pool_oe     (pool_oe),
    .w_pool_size (w_pool_size)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  // outputs sampled mid cycle, tagged with the edge that set them
  always @(negedge clk)
    if (xrst)
    begin
      if (out_valid)
        valid_q.push_back(cyc);
      if (pool_oe)
        oe_q.push_back(cyc);
      if (out_begin)
        begin_q.push_back(cyc);
      if (out_end)
        end_q.push_back(cyc);
      if (buf_feat_en)
        bfe_q.push_back(cyc);
    end

  // galois form, taps 32 30 26 25
  function automatic logic random_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  task automatic compare_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic compare_size(input string name, input size_t exp, input size_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp)
    begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_edges(input string name, input int exp_q[$], input int act_q[$]);
    int i;
    compare_count({name, " pulse count"}, exp_q.size(), act_q.size());
    for (i = 0; i < exp_q.size() && i < act_q.size(); i++)
      compare_count($sformatf("%s pulse %0d edge", name, i), exp_q[i], act_q[i]);
  endtask

  task automatic check_outputs_low(input string name);
    compare_bit({name, " buf_feat_en"}, 1'b0, buf_feat_en);
    compare_bit({name, " out_begin"}, 1'b0, out_begin);
    compare_bit({name, " out_valid"}, 1'b0, out_valid);
    compare_bit({name, " out_end"}, 1'b0, out_end);
    compare_bit({name, " pool_oe"}, 1'b0, pool_oe);
    compare_size({name, " w_pool_size"}, '0, w_pool_size);
  endtask

  task automatic clear_queues();
    exp_valid_q.delete();
    exp_begin_q.delete();
    exp_end_q.delete();
    exp_bfe_q.delete();
    valid_q.delete();
    oe_q.delete();
    begin_q.delete();
    end_q.delete();
    bfe_q.delete();
  endtask

  task automatic wait_frame_end(input string name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!out_end && waited < FRAME_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!out_end)
    begin
      errors++;
      $display("%s: out_end never came, gave up after %0d cycles", name, waited);
    end
    repeat (3) @(posedge clk);  // lets the monitor catch late pulses
  endtask

  // one frame in raster order, events predicted per accepted pixel
  task automatic run_frame(input string name, input size_t fea, input size_t pool,
                           input bit gaps, input bit extra_begin);
    int         f;
    int         p;
    int         tap;
    int         acc;
    int         x;
    int         y;
    logic [1:0] gap;
    int         oe_exp[$];
    f   = int'(fea);
    p   = int'(pool);
    tap = f - p + POOL_PIPE_LATENCY - 1;
    clear_queues();
    @(posedge clk);
    fea_size  <= fea;
    pool_size <= pool;
    in_begin  <= 1'b1;
    exp_bfe_q.push_back(cyc + 2);  // cyc still holds the previous edge
    @(posedge clk);
    for (y = 0; y < f; y++)
      for (x = 0; x < f; x++)
      begin
        in_begin <= 1'b0;
        if (gaps)
        begin
          gap = {random_bit(), random_bit()};
          repeat (gap)
          begin
            in_valid <= 1'b0;
            in_end   <= 1'b0;
            @(posedge clk);
          end
        end
        in_valid <= 1'b1;
        in_end   <= (x == f - 1) && (y == f - 1);
        acc = cyc + 2;
        if (x % p == p - 1 && y % p == p - 1)
          exp_valid_q.push_back(acc + tap + OUT_STAGES);
        if (x == p - 2 && y == p - 1)
          exp_begin_q.push_back(acc + tap + OUT_STAGES);
        if (x == f - 1 && y == f - 1)
          exp_end_q.push_back(acc + tap + OUT_STAGES);
        if (extra_begin && x == 0 && y == 1)
        begin
          in_begin  <= 1'b1;  // sizes must stay latched
          fea_size  <= {fea[LWIDTH-2:0], 1'b0};
          pool_size <= pool + size_t'(1);
          exp_bfe_q.push_back(acc);
        end
        @(posedge clk);
      end
    in_valid <= 1'b0;
    in_end   <= 1'b0;
    in_begin <= 1'b0;
    wait_frame_end(name);
    foreach (exp_valid_q[i])
      oe_exp.push_back(exp_valid_q[i] - 1);
    check_edges({name, " out_valid"}, exp_valid_q, valid_q);
    check_edges({name, " pool_oe"}, oe_exp, oe_q);
    check_edges({name, " out_begin"}, exp_begin_q, begin_q);
    check_edges({name, " out_end"}, exp_end_q, end_q);
    check_edges({name, " buf_feat_en"}, exp_bfe_q, bfe_q);
    compare_size({name, " w_pool_size"}, pool, w_pool_size);
  endtask

  task automatic test_reset();
    int i;
    for (i = 1; i <= 4; i++)
    begin
      @(posedge clk);
      if (i == 4)
        xrst <= 1'b1;
      @(negedge clk);
      check_outputs_low($sformatf("reset cycle %0d", i));
    end
    repeat (2)
    begin
      @(negedge clk);
      check_outputs_low("after reset");
    end
  endtask

  task automatic test_frame_start();
    run_frame("frame start", 8'd4, 8'd2, 1'b0, 1'b0);
    compare_count("frame start buf_feat_en cycles", 1, bfe_q.size());
  endtask

  task automatic test_continuous();
    run_frame("2x2 on 8x8", 8'd8, 8'd2, 1'b0, 1'b0);
    compare_count("2x2 on 8x8 windows", 16, valid_q.size());
  endtask

  task automatic test_gaps();
    run_frame("3x3 on 9x9 gaps", 8'd9, 8'd3, 1'b1, 1'b0);
    compare_count("3x3 on 9x9 gaps windows", 9, valid_q.size());
  endtask

  task automatic test_framing();
    run_frame("framing 6x6", 8'd6, 8'd2, 1'b0, 1'b1);
    compare_count("framing 6x6 out_begin", 1, begin_q.size());
    compare_count("framing 6x6 out_end", 1, end_q.size());
    run_frame("framing 16x16", 8'd16, 8'd8, 1'b1, 1'b0);
    compare_count("framing 16x16 windows", 4, valid_q.size());
    compare_count("framing 16x16 out_end", 1, end_q.size());
  endtask

  initial
  begin
    xrst      = 1'b0;
    in_begin  = 1'b0;
    in_valid  = 1'b0;
    in_end    = 1'b0;
    fea_size  = '0;
    pool_size = '0;
    errors    = 0;
    checks    = 0;
    cyc       = 0;
    lfsr      = 32'hac68_db83;
    test_reset();
    test_frame_start();
    test_continuous();
    test_gaps();
    test_framing();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== src.f ====
common/pool_pkg.sv
common/pool_event_if.sv
pool_scan/pool_scan.sv
hdl/pool_align.sv
hdl/pool_ctrl.sv
verification/tb_pool_ctrl.sv

// ==== Makefile ====
TOP = tb_pool_ctrl
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
